// File: Bender.yml
package:
  name: riscCore

sources:
  - src/isaPkg.sv
  - src/pipePkg.sv
  - src/memIf.sv
  - src/stageReg.sv
  - src/wordMemory.sv
  - src/decodeStage.sv
  - src/hazardUnit.sv
  - src/execUnit.sv
  - src/riscCore.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/riscCore_checker.sv
      - sim/riscCore_tb.sv

// File: sim/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int periodNs    = 20,
  parameter int resetCycles = 4
) (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #(periodNs / 2) clock = ~clock;
  end

  // Active low reset released on a rising edge
  initial
  begin
    reset = 1'b0;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

// File: sim/riscCore_checker.sv
`timescale 1ns/1ps

module riscCore_checker (
  input logic       clock,
  input logic       reset,
  input logic       retireValid,
  input logic [4:0] retireRd,
  input logic       storeValid,
  input logic       stall
);

  // x0 writes are dropped in decode
  retireNeedsRd: assert property (@(posedge clock) disable iff (!reset)
    retireValid |-> (retireRd != 5'd0))
    else $error("retire event reports register x0");

  // Pipeline starts out empty
  quietAfterReset: assert property (@(posedge clock)
    $rose(reset) |-> (!retireValid && !storeValid))
    else $error("retire or store event in the first cycle after reset");

  // A load-use hazard costs exactly one cycle
  singleStall: assert property (@(posedge clock) disable iff (!reset)
    stall |=> !stall)
    else $error("stall held for two cycles in a row");

endmodule

bind riscCore riscCore_checker ruleCheck (
  .clock(clock), .reset(reset), .retireValid(retireValid), .retireRd(retireRd),
  .storeValid(storeValid), .stall(stall)
);

// File: sim/riscCore_tb.sv
`timescale 1ns/1ps

module riscCore_tb;

  localparam int evNone   = 0;
  localparam int evRetire = 1;
  localparam int evStore  = 2;

  localparam logic [6:0] opImm  = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;

  // Fetch at cycle 1 after reset release retires four cycles later
  localparam int firstEventCycle = 5;
  localparam int settleCycles    = 20;

  logic        clock;
  logic        clockReset;
  logic        loadDone;
  logic        coreReset;
  logic        progWrite;
  logic [31:0] progAddr;
  logic [31:0] progData;
  logic        retireValid;
  logic [4:0]  retireRd;
  logic [31:0] retireData;
  logic        storeValid;
  logic [31:0] storeAddr;
  logic [31:0] storeData;

  string       rowName [$];
  logic [31:0] rowInstr [$];
  int          rowKind [$];
  logic [31:0] rowTarget [$];
  logic [31:0] rowValue [$];
  bit          rowRandom [$];
  int          expectRows [$];
  int          tableRows = 0;
  int          errorCount = 0;
  logic [31:0] rngState = 32'd82;

  clockGen #(.periodNs(20), .resetCycles(4)) clocks (.clock(clock), .reset(clockReset));

  // Core stays in reset until the program is in place
  assign coreReset = clockReset && loadDone;

  riscCore #(.memWords(256)) dut (
    .clock(clock), .reset(coreReset),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
    .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // RV32I encodings
  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input int imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opcode);
    logic [31:0] v;
    v = imm;
    return {v[11:0], rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] sType(input int imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    logic [31:0] v;
    v = imm;
    return {v[11:5], rs2, rs1, 3'b010, v[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] bType(input int imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    logic [31:0] v;
    v = imm;
    return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jType(input int imm, input logic [4:0] rd);
    logic [31:0] v;
    v = imm;
    return {v[20], v[10:1], v[11], v[19:12], rd, 7'b1101111};
  endfunction

  task automatic addRow(input string name, input logic [31:0] instr, input int kind,
      input logic [31:0] target, input logic [31:0] value, input bit randomImm);
    rowName.push_back(name);
    rowInstr.push_back(instr);
    rowKind.push_back(kind);
    rowTarget.push_back(target);
    rowValue.push_back(value);
    rowRandom.push_back(randomImm);
  endtask

  task automatic abortRun(input string reason);
    errorCount++;
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected)
    begin
      errorCount++;
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // Row i sits at byte address 4*i
  // Target holds rd or the store address
  task automatic buildTable();
    addRow("addi x1", iType(5, 0, 3'b000, 1, opImm), evRetire, 1, 5, 0);
    addRow("addi x2", iType(3, 0, 3'b000, 2, opImm), evRetire, 2, 3, 0);
    addRow("add x3", rType(7'h00, 2, 1, 3'b000, 3), evRetire, 3, 8, 0);
    addRow("sub x4", rType(7'h20, 1, 3, 3'b000, 4), evRetire, 4, 3, 0);
    addRow("and x5", rType(7'h00, 1, 4, 3'b111, 5), evRetire, 5, 1, 0);
    addRow("or x6", rType(7'h00, 3, 5, 3'b110, 6), evRetire, 6, 9, 0);
    addRow("xor x7", rType(7'h00, 4, 6, 3'b100, 7), evRetire, 7, 10, 0);
    addRow("addi x8 neg", iType(-7, 0, 3'b000, 8, opImm), evRetire, 8, 32'hFFFF_FFF9, 0);
    addRow("slt x9", rType(7'h00, 1, 8, 3'b010, 9), evRetire, 9, 1, 0);
    addRow("slt x11", rType(7'h00, 8, 1, 3'b010, 11), evRetire, 11, 0, 0);
    // Immediates and values filled in by patchRandom
    addRow("addi x12 random", iType(0, 0, 3'b000, 12, opImm), evRetire, 12, 0, 1);
    addRow("addi x13 random", iType(0, 0, 3'b000, 13, opImm), evRetire, 13, 0, 1);
    addRow("addi x14 random", iType(0, 0, 3'b000, 14, opImm), evRetire, 14, 0, 1);
    addRow("addi x0", iType(99, 0, 3'b000, 0, opImm), evNone, 0, 0, 0);
    addRow("addi x15 base", iType(64, 0, 3'b000, 15, opImm), evRetire, 15, 64, 0);
    addRow("sw x7", sType(4, 7, 15), evStore, 68, 10, 0);
    addRow("lw x16", iType(4, 15, 3'b010, 16, opLoad), evRetire, 16, 10, 0);
    addRow("add x17 load use", rType(7'h00, 1, 16, 3'b000, 17), evRetire, 17, 15, 0);
    addRow("beq taken", bType(12, 1, 1, 3'b000), evNone, 0, 0, 0);
    addRow("skip after beq 1", iType(1, 0, 3'b000, 18, opImm), evNone, 0, 0, 0);
    addRow("skip after beq 2", iType(2, 0, 3'b000, 18, opImm), evNone, 0, 0, 0);
    addRow("addi x19", iType(21, 0, 3'b000, 19, opImm), evRetire, 19, 21, 0);
    addRow("bne taken", bType(12, 2, 19, 3'b001), evNone, 0, 0, 0);
    addRow("skip after bne 1", iType(3, 0, 3'b000, 18, opImm), evNone, 0, 0, 0);
    addRow("skip after bne 2", iType(4, 0, 3'b000, 18, opImm), evNone, 0, 0, 0);
    addRow("beq not taken", bType(8, 2, 1, 3'b000), evNone, 0, 0, 0);
    addRow("addi x20", iType(26, 0, 3'b000, 20, opImm), evRetire, 20, 26, 0);
    addRow("bne not taken", bType(8, 1, 1, 3'b001), evNone, 0, 0, 0);
    addRow("addi x21", iType(28, 0, 3'b000, 21, opImm), evRetire, 21, 28, 0);
    addRow("jal x22", jType(8, 22), evRetire, 22, 120, 0);
    addRow("skip after jal", iType(5, 0, 3'b000, 18, opImm), evNone, 0, 0, 0);
    addRow("add x23 link", rType(7'h00, 1, 22, 3'b000, 23), evRetire, 23, 125, 0);
    // Spin here once the program is done
    addRow("jal x0 self", jType(0, 0), evNone, 0, 0, 0);
  endtask

  task automatic patchRandom();
    logic [31:0] word;
    logic [11:0] imm;
    for (int i = 0; i < rowInstr.size(); i++)
    begin
      if (rowRandom[i])
      begin
        rngState = xorshift(rngState);
        imm = rngState[11:0];
        word = rowInstr[i];
        word[31:20] = imm;
        rowInstr[i] = word;
        rowValue[i] = {{20{imm[11]}}, imm};
      end
    end
  endtask

  task automatic matchEvent(input int next, input int kind, input logic [31:0] target,
      input logic [31:0] value);
    int row;
    if (next >= expectRows.size())
    begin
      abortRun("The core reported more retire or store events than the program has");
    end
    else
    begin
      row = expectRows[next];
      checkValue({rowName[row], " kind"}, rowKind[row], kind);
      checkValue({rowName[row], " target"}, rowTarget[row], target);
      checkValue({rowName[row], " value"}, rowValue[row], value);
    end
  endtask

  // Outputs are sampled on the falling edge between register updates
  task automatic runEvents();
    int   cycle;
    int   next;
    logic stallPrev;
    cycle = 0;
    next = 0;
    stallPrev = 1'b0;
    wait (coreReset === 1'b1);
    while (next < expectRows.size())
    begin
      @(negedge clock);
      cycle++;
      checkValue("stall run", 0, {31'd0, dut.stall & stallPrev});
      stallPrev = dut.stall;
      if ((retireValid || storeValid) && next == 0)
        checkValue("first event cycle", firstEventCycle, cycle);
      // The older instruction sits in writeback
      if (retireValid)
      begin
        matchEvent(next, evRetire, {27'd0, retireRd}, retireData);
        next++;
      end
      if (storeValid)
      begin
        matchEvent(next, evStore, storeAddr, storeData);
        next++;
      end
    end
    repeat (settleCycles)
    begin
      @(negedge clock);
      if (retireValid || storeValid)
        abortRun("An event appeared after the last expected one");
    end
  endtask

  initial
  begin
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    loadDone  = 1'b0;
    buildTable();
    patchRandom();
    for (int i = 0; i < rowKind.size(); i++)
    begin
      if (rowKind[i] != evNone)
        expectRows.push_back(i);
    end
    tableRows = rowInstr.size();

    // Program load while the core is held in reset
    for (int i = 0; i < tableRows; i++)
    begin
      @(posedge clock);
      progWrite <= 1'b1;
      progAddr  <= i * 4;
      progData  <= rowInstr[i];
    end
    @(posedge clock);
    progWrite <= 1'b0;
    loadDone  <= 1'b1;

    runEvents();
    if (errorCount == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
    begin
      $display("CHECKS FAILED");
      $fatal(1, "errors were recorded");
    end
  end

  // Watchdog
  initial
  begin
    wait (tableRows > 0);
    repeat (tableRows * 8 + 50) @(posedge clock);
    abortRun("Timeout: the program did not finish within its cycle budget");
  end

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic                     clock,
  input  logic                     reset,
  input  pipePkg::ifIdT            ifId,
  input  logic [4:0]               wbRd,
  input  logic [pipePkg::xlen-1:0] wbData,
  input  logic                     wbWrite,
  output pipePkg::idExT            idEx,
  output logic                     jalTaken,
  output logic [pipePkg::xlen-1:0] jalTarget
);

  logic [31:0]              instr;
  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [4:0]               rs1;
  logic [4:0]               rs2;
  logic [4:0]               rd;
  logic [pipePkg::xlen-1:0] imm;
  logic [pipePkg::xlen-1:0] rs1Data;
  logic [pipePkg::xlen-1:0] rs2Data;
  logic [pipePkg::xlen-1:0] regs [32];
  isaPkg::immFmtT           immFmt;
  isaPkg::aluOpT            aluOp;
  logic                     aluSrcImm;
  logic                     isBranch;
  logic                     memRead;
  logic                     memWrite;
  logic                     writesRd;
  logic                     isJal;

  assign instr  = ifId.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Main control
  always_comb
  begin
    immFmt    = isaPkg::fmtI;
    aluOp     = isaPkg::aluAdd;
    aluSrcImm = 1'b0;
    isBranch  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    writesRd  = 1'b0;
    isJal     = 1'b0;
    case (opcode)
      isaPkg::opOp:
      begin
        writesRd = 1'b1;
        case (funct3)
          isaPkg::f3AddSub: aluOp = instr[30] ? isaPkg::aluSub : isaPkg::aluAdd;
          isaPkg::f3Slt:    aluOp = isaPkg::aluSlt;
          isaPkg::f3Xor:    aluOp = isaPkg::aluXor;
          isaPkg::f3Or:     aluOp = isaPkg::aluOr;
          isaPkg::f3And:    aluOp = isaPkg::aluAnd;
          default:          aluOp = isaPkg::aluAdd;
        endcase
      end
      isaPkg::opImm:
      begin
        aluSrcImm = 1'b1;
        writesRd  = 1'b1;
      end
      isaPkg::opLoad:
      begin
        aluSrcImm = 1'b1;
        memRead   = 1'b1;
        writesRd  = 1'b1;
      end
      isaPkg::opStore:
      begin
        immFmt    = isaPkg::fmtS;
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
      end
      isaPkg::opBranch:
      begin
        immFmt   = isaPkg::fmtB;
        isBranch = 1'b1;
      end
      isaPkg::opJal:
      begin
        immFmt   = isaPkg::fmtJ;
        isJal    = 1'b1;
        writesRd = 1'b1;
      end
      // Bubbles and unknown opcodes do nothing
      default: ;
    endcase
  end

  always_comb
  begin
    case (immFmt)
      isaPkg::fmtS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      isaPkg::fmtB: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      isaPkg::fmtJ: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:      imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

  // Register file with x0 never written
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wbWrite && wbRd != 5'd0)
    begin
      regs[wbRd] <= wbData;
    end
  end

  // Reads see the value written back in the same cycle
  always_comb
  begin
    rs1Data = regs[rs1];
    rs2Data = regs[rs2];
    if (rs1 == 5'd0)
      rs1Data = '0;
    else if (wbWrite && wbRd == rs1)
      rs1Data = wbData;
    if (rs2 == 5'd0)
      rs2Data = '0;
    else if (wbWrite && wbRd == rs2)
      rs2Data = wbData;
  end

  always_comb
  begin
    idEx.pc        = ifId.pc;
    idEx.rs1Data   = rs1Data;
    idEx.rs2Data   = rs2Data;
    idEx.imm       = imm;
    idEx.rs1       = rs1;
    idEx.rs2       = rs2;
    idEx.rd        = rd;
    idEx.aluOp     = aluOp;
    idEx.aluSrcImm = aluSrcImm;
    idEx.isBranch  = isBranch;
    idEx.branchNe  = funct3[0];
    idEx.memRead   = memRead;
    idEx.memWrite  = memWrite;
    // Writes to x0 are dropped here so they never retire
    idEx.regWrite  = writesRd && (rd != 5'd0);
    idEx.isJal     = isJal;
    idEx.linkPc    = ifId.pc + pipePkg::pcStep;
  end

  assign jalTaken  = isJal;
  assign jalTarget = ifId.pc + imm;

endmodule

// File: src/execUnit.sv
`timescale 1ns/1ps

module execUnit (
  input  pipePkg::idExT            idEx,
  input  pipePkg::fwdSelT          fwdA,
  input  pipePkg::fwdSelT          fwdB,
  input  logic [pipePkg::xlen-1:0] memResult,
  input  logic [pipePkg::xlen-1:0] wbResult,
  output pipePkg::exMemT           exMem,
  output logic                     branchTaken,
  output logic [pipePkg::xlen-1:0] branchTarget
);

  logic [pipePkg::xlen-1:0] opA;
  logic [pipePkg::xlen-1:0] opB;
  logic [pipePkg::xlen-1:0] aluB;
  logic [pipePkg::xlen-1:0] aluResult;
  logic                     lessThan;

  always_comb
  begin
    case (fwdA)
      pipePkg::fwdMem: opA = memResult;
      pipePkg::fwdWb:  opA = wbResult;
      default:         opA = idEx.rs1Data;
    endcase
    case (fwdB)
      pipePkg::fwdMem: opB = memResult;
      pipePkg::fwdWb:  opB = wbResult;
      default:         opB = idEx.rs2Data;
    endcase
  end

  assign aluB     = idEx.aluSrcImm ? idEx.imm : opB;
  assign lessThan = $signed(opA) < $signed(aluB);

  always_comb
  begin
    case (idEx.aluOp)
      isaPkg::aluSub: aluResult = opA - aluB;
      isaPkg::aluAnd: aluResult = opA & aluB;
      isaPkg::aluOr:  aluResult = opA | aluB;
      isaPkg::aluXor: aluResult = opA ^ aluB;
      isaPkg::aluSlt: aluResult = {{(pipePkg::xlen-1){1'b0}}, lessThan};
      default:        aluResult = opA + aluB;
    endcase
  end

  // beq when branchNe is low, bne when high
  assign branchTaken  = idEx.isBranch && ((opA == opB) != idEx.branchNe);
  assign branchTarget = idEx.pc + idEx.imm;

  always_comb
  begin
    exMem.aluOut    = idEx.isJal ? idEx.linkPc : aluResult;
    exMem.storeData = opB;
    exMem.rd        = idEx.rd;
    exMem.memRead   = idEx.memRead;
    exMem.memWrite  = idEx.memWrite;
    exMem.regWrite  = idEx.regWrite;
  end

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  logic [4:0]      ifRs1,
  input  logic [4:0]      ifRs2,
  input  pipePkg::idExT   idEx,
  input  pipePkg::exMemT  exMem,
  input  pipePkg::memWbT  memWb,
  input  logic            branchTaken,
  input  logic            jalTaken,
  output logic            stall,
  output logic            flushIf,
  output logic            flushId,
  output pipePkg::fwdSelT fwdA,
  output pipePkg::fwdSelT fwdB
);

  // Youngest producer wins
  function automatic pipePkg::fwdSelT pickSource(
    input logic [4:0] rs,
    input logic [4:0] memRd,
    input logic       memWrite,
    input logic [4:0] wbRd,
    input logic       wbWrite
  );
    if (memWrite && memRd != 5'd0 && memRd == rs)
      return pipePkg::fwdMem;
    else if (wbWrite && wbRd != 5'd0 && wbRd == rs)
      return pipePkg::fwdWb;
    else
      return pipePkg::fwdReg;
  endfunction

  // Load result is not ready for the next instruction
  assign stall = idEx.memRead && (idEx.rd != 5'd0)
                 && ((idEx.rd == ifRs1) || (idEx.rd == ifRs2));

  assign flushIf = branchTaken || jalTaken;
  assign flushId = branchTaken;

  assign fwdA = pickSource(idEx.rs1, exMem.rd, exMem.regWrite, memWb.rd, memWb.regWrite);
  assign fwdB = pickSource(idEx.rs2, exMem.rd, exMem.regWrite, memWb.rd, memWb.regWrite);

endmodule

// File: src/isaPkg.sv
package isaPkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opStore  = 7'b0100011,
    opOp     = 7'b0110011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt
  } aluOpT;

  // Immediate layout picked by decode
  typedef enum logic [1:0] {
    fmtI,
    fmtS,
    fmtB,
    fmtJ
  } immFmtT;

  // funct3 of the R-type operations
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;

  // addi x0, x0, 0
  localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage

// File: src/memIf.sv
`timescale 1ns/1ps

interface memIf;

  logic                     enable;
  logic                     write;
  logic [pipePkg::xlen-1:0] addr;
  logic [pipePkg::xlen-1:0] wdata;
  // Valid in the same cycle as addr
  logic [pipePkg::xlen-1:0] rdata;

  modport master (output enable, output write, output addr, output wdata, input rdata);

  modport slave (input enable, input write, input addr, input wdata, output rdata);

endinterface

// File: src/pipePkg.sv
package pipePkg;

  localparam int xlen = 32;

  // Sequential PC increment
  localparam logic [xlen-1:0] pcStep = 4;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
  } ifIdT;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    isaPkg::aluOpT   aluOp;
    logic            aluSrcImm;
    logic            isBranch;
    logic            branchNe;
    logic            memRead;
    logic            memWrite;
    logic            regWrite;
    logic            isJal;
    logic [xlen-1:0] linkPc;
  } idExT;

  typedef struct packed {
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] storeData;
    logic [4:0]      rd;
    logic            memRead;
    logic            memWrite;
    logic            regWrite;
  } exMemT;

  typedef struct packed {
    logic [xlen-1:0] result;
    logic [4:0]      rd;
    logic            regWrite;
  } memWbT;

  // Operand source for execute
  typedef enum logic [1:0] {
    fwdReg,
    fwdMem,
    fwdWb
  } fwdSelT;

endpackage

// File: src/riscCore.sv
`timescale 1ns/1ps

module riscCore #(
  parameter int memWords = 256
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     progWrite,
  input  logic [pipePkg::xlen-1:0] progAddr,
  input  logic [pipePkg::xlen-1:0] progData,
  output logic                     retireValid,
  output logic [4:0]               retireRd,
  output logic [pipePkg::xlen-1:0] retireData,
  output logic                     storeValid,
  output logic [pipePkg::xlen-1:0] storeAddr,
  output logic [pipePkg::xlen-1:0] storeData
);

  logic [pipePkg::xlen-1:0] pc;
  logic [pipePkg::xlen-1:0] pcNext;
  logic [pipePkg::xlen-1:0] jalTarget;
  logic [pipePkg::xlen-1:0] branchTarget;
  logic [6:0]               ifOpcode;
  logic [4:0]               ifRs1;
  logic [4:0]               ifRs2;
  logic                     jalTaken;
  logic                     branchTaken;
  logic                     stall;
  logic                     flushIf;
  logic                     flushId;
  pipePkg::fwdSelT          fwdA;
  pipePkg::fwdSelT          fwdB;
  pipePkg::ifIdT            ifIdIn;
  pipePkg::ifIdT            ifId;
  pipePkg::idExT            idExIn;
  pipePkg::idExT            idEx;
  pipePkg::exMemT           exMemIn;
  pipePkg::exMemT           exMem;
  pipePkg::memWbT           memWbIn;
  pipePkg::memWbT           memWb;

  memIf imemBus ();
  memIf dmemBus ();

  // Branch beats the load-use hold and jal comes last
  always_comb
  begin
    if (branchTaken)
      pcNext = branchTarget;
    else if (stall)
      pcNext = pc;
    else if (jalTaken)
      pcNext = jalTarget;
    else
      pcNext = pc + pipePkg::pcStep;
  end

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      pc <= '0;
    else
      pc <= pcNext;
  end

  // Program loader owns instruction memory during reset
  assign imemBus.enable = reset ? 1'b1 : progWrite;
  assign imemBus.write  = reset ? 1'b0 : progWrite;
  assign imemBus.addr   = reset ? pc : progAddr;
  assign imemBus.wdata  = progData;

  wordMemory #(.memWords(memWords)) imem (.clock(clock), .port(imemBus.slave));

  // Flushed fetch becomes a nop
  assign ifIdIn.pc    = pc;
  assign ifIdIn.instr = flushIf ? isaPkg::nopInstr : imemBus.rdata;

  stageReg #(.payloadT(pipePkg::ifIdT)) ifIdReg (
    .clock(clock), .reset(reset), .hold(stall), .bubble(1'b0), .d(ifIdIn), .q(ifId)
  );

  decodeStage decode (
    .clock(clock), .reset(reset), .ifId(ifId),
    .wbRd(memWb.rd), .wbData(memWb.result), .wbWrite(memWb.regWrite),
    .idEx(idExIn), .jalTaken(jalTaken), .jalTarget(jalTarget)
  );

  // Only real source operands may cause a stall
  assign ifOpcode = ifId.instr[6:0];
  assign ifRs1    = (ifOpcode == isaPkg::opJal) ? 5'd0 : ifId.instr[19:15];
  assign ifRs2    = (ifOpcode == isaPkg::opOp || ifOpcode == isaPkg::opStore
                     || ifOpcode == isaPkg::opBranch) ? ifId.instr[24:20] : 5'd0;

  hazardUnit hazard (
    .ifRs1(ifRs1), .ifRs2(ifRs2), .idEx(idEx), .exMem(exMem), .memWb(memWb),
    .branchTaken(branchTaken), .jalTaken(jalTaken),
    .stall(stall), .flushIf(flushIf), .flushId(flushId), .fwdA(fwdA), .fwdB(fwdB)
  );

  stageReg #(.payloadT(pipePkg::idExT)) idExReg (
    .clock(clock), .reset(reset), .hold(1'b0), .bubble(stall || flushId),
    .d(idExIn), .q(idEx)
  );

  execUnit execute (
    .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
    .memResult(exMem.aluOut), .wbResult(memWb.result),
    .exMem(exMemIn), .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

  stageReg #(.payloadT(pipePkg::exMemT)) exMemReg (
    .clock(clock), .reset(reset), .hold(1'b0), .bubble(1'b0), .d(exMemIn), .q(exMem)
  );

  assign dmemBus.enable = exMem.memRead || exMem.memWrite;
  assign dmemBus.write  = exMem.memWrite;
  assign dmemBus.addr   = exMem.aluOut;
  assign dmemBus.wdata  = exMem.storeData;

  wordMemory #(.memWords(memWords)) dmem (.clock(clock), .port(dmemBus.slave));

  // Writeback picks the loaded word or the ALU result
  assign memWbIn.result   = exMem.memRead ? dmemBus.rdata : exMem.aluOut;
  assign memWbIn.rd       = exMem.rd;
  assign memWbIn.regWrite = exMem.regWrite;

  stageReg #(.payloadT(pipePkg::memWbT)) memWbReg (
    .clock(clock), .reset(reset), .hold(1'b0), .bubble(1'b0), .d(memWbIn), .q(memWb)
  );

  assign retireValid = memWb.regWrite;
  assign retireRd    = memWb.rd;
  assign retireData  = memWb.result;

  assign storeValid = exMem.memWrite;
  assign storeAddr  = exMem.aluOut;
  assign storeData  = exMem.storeData;

endmodule

// File: src/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    hold,
  input  logic    bubble,
  input  payloadT d,
  output payloadT q
);

  // All-zero payload leaves every control bit inactive
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      q <= '0;
    end
    else if (bubble)
    begin
      q <= '0;
    end
    else if (!hold)
    begin
      q <= d;
    end
  end

endmodule

// File: src/wordMemory.sv
`timescale 1ns/1ps

module wordMemory #(
  parameter int memWords = 256
) (
  input logic  clock,
  memIf.slave  port
);

  localparam int idxBits = $clog2(memWords);

  logic [pipePkg::xlen-1:0] words [memWords];
  logic [idxBits-1:0]       index;

  // Word index from the byte address
  assign index = port.addr[idxBits+1:2];

  assign port.rdata = words[index];

  always_ff @(posedge clock)
  begin
    if (port.enable && port.write)
    begin
      words[index] <= port.wdata;
    end
  end

endmodule

// File: vlog.f
src/isaPkg.sv
src/pipePkg.sv
src/memIf.sv
src/stageReg.sv
src/wordMemory.sv
src/decodeStage.sv
src/hazardUnit.sv
src/execUnit.sv
src/riscCore.sv
sim/clockGen.sv
sim/riscCore_checker.sv
sim/riscCore_tb.sv
